/* common/ppu_config.svh */
`ifndef PPU_CONFIG_SVH
`define PPU_CONFIG_SVH

// ======================================================================
// Plane and row geometry
// ======================================================================
`define PPU_PLANE_ROWS    32    // Rows per layer plane
`define PPU_PLANE_COLS    64    // Pixels per plane row
`define PPU_ROW_PIXELS    32    // Visible pixels per rendered row

// ======================================================================
// VRAM word layout
// ======================================================================
`define PPU_PIX_BITS      4     // Colour index width
`define PPU_PIX_PER_WORD  16
`define PPU_WORD_BITS     (`PPU_PIX_BITS * `PPU_PIX_PER_WORD)
`define PPU_BYTE_EN_BITS  (`PPU_WORD_BITS / 8)

// Words per plane row and per plane
`define PPU_WORDS_PER_ROW (`PPU_PLANE_COLS / `PPU_PIX_PER_WORD)
`define PPU_PLANE_WORDS   (`PPU_PLANE_ROWS * `PPU_WORDS_PER_ROW)

// Plane select bit sits on top of the plane word address
`define PPU_VRAM_AW       ($clog2(`PPU_PLANE_WORDS) + 1)

`endif

/* common/ppu_types_pkg.sv */
`include "ppu_config.svh"

package ppu_types_pkg;

    // ==================================================================
    // Pixel values
    // ==================================================================
    typedef logic [`PPU_PIX_BITS-1:0] color_idx_t;  // 0 is transparent
    typedef logic [`PPU_PIX_BITS:0]   pixel_t;      // {fg flag, index}, 0 is backdrop

    // ==================================================================
    // Coordinates
    // ==================================================================
    typedef logic [$clog2(`PPU_PLANE_ROWS)-1:0] row_t;   // Plane or screen row
    typedef logic [$clog2(`PPU_PLANE_COLS)-1:0] col_t;   // Plane column
    typedef logic [$clog2(`PPU_ROW_PIXELS)-1:0] xpos_t;  // Screen column

    // ==================================================================
    // VRAM port fields
    // ==================================================================
    // Address: [7] plane, [6:2] row, [1:0] word in row
    typedef logic [`PPU_VRAM_AW-1:0]      vram_addr_t;
    typedef logic [`PPU_WORD_BITS-1:0]    vram_data_t;
    typedef logic [`PPU_BYTE_EN_BITS-1:0] vram_be_t;   // One bit per two pixels

endpackage : ppu_types_pkg

/* common/ppu_bus_pkg.sv */
package ppu_bus_pkg;

    import ppu_types_pkg::*;

    // ==================================================================
    // CPU write port
    // ==================================================================
    // No handshake here, the CPU watches cpu_wr_busy instead
    typedef struct packed {
        logic       we;
        vram_addr_t addr;
        vram_data_t data;   // Pixel p at bits 4p+3:4p
        vram_be_t   be;     // Byte k holds pixels 2k and 2k+1
    } vram_wr_t;

    // ==================================================================
    // Per-layer control
    // ==================================================================
    typedef struct packed {
        col_t scroll_x;     // Wraps mod 64
        row_t scroll_y;     // Wraps mod 32
        logic enable;
    } layer_ctrl_t;

    // ==================================================================
    // Renderer output stream
    // ==================================================================
    typedef struct packed {
        logic       valid;
        xpos_t      x;
        color_idx_t index;
    } layer_pix_t;

endpackage : ppu_bus_pkg

/* ppu/layer_renderer.sv */
`timescale 1ns/1ps
`include "ppu_config.svh"

module layer_renderer #(
    parameter logic PLANE_SEL = 1'b0    // Address bit 7 value owned here
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ppu_bus_pkg::vram_wr_t    vram_wr,
    input  logic                     start,
    input  ppu_types_pkg::row_t      row,
    input  ppu_bus_pkg::layer_ctrl_t ctrl,
    output ppu_bus_pkg::layer_pix_t  pix
);

    import ppu_types_pkg::*;
    import ppu_bus_pkg::*;

    localparam int    LOCAL_AW = $clog2(`PPU_PLANE_WORDS);
    localparam int    SUB_W    = $clog2(`PPU_PIX_PER_WORD);
    localparam int    WSEL_W   = $clog2(`PPU_WORDS_PER_ROW);
    localparam int    BYTE_W   = $bits(vram_data_t) / $bits(vram_be_t);
    localparam xpos_t LAST_X   = xpos_t'(`PPU_ROW_PIXELS - 1);

    vram_data_t mem [`PPU_PLANE_WORDS];

    logic                wr_hit;
    logic                running;
    logic                step;
    logic                rendering;
    xpos_t               x_cnt;
    xpos_t               step_x;
    row_t                src_row;
    col_t                src_col;

    logic                s1_valid;
    xpos_t               s1_x;
    logic [LOCAL_AW-1:0] s1_addr;
    logic [SUB_W-1:0]    s1_sub;

    logic                out_valid;
    xpos_t               out_x;
    logic [SUB_W-1:0]    out_sub;
    vram_data_t          rd_word;

    // ==================================================================
    // CPU writes into this plane
    // ==================================================================
    assign wr_hit = vram_wr.we && (vram_wr.addr[`PPU_VRAM_AW-1] == PLANE_SEL);

    always_ff @(posedge clk) begin
        if (wr_hit) begin
            for (int k = 0; k < $bits(vram_be_t); k++) begin
                if (vram_wr.be[k]) begin
                    mem[vram_wr.addr[LOCAL_AW-1:0]][BYTE_W*k +: BYTE_W] <=
                        vram_wr.data[BYTE_W*k +: BYTE_W];
                end
            end
        end
    end

    // ==================================================================
    // Scrolled fetch, one screen column per cycle
    // ==================================================================
    assign step    = start || running;
    assign step_x  = start ? '0 : x_cnt;
    assign src_row = row + ctrl.scroll_y;                 // Wraps at 32
    assign src_col = col_t'(step_x) + ctrl.scroll_x;      // Wraps at 64

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running   <= 1'b0;
            x_cnt     <= '0;
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (start) begin
                running <= 1'b1;
                x_cnt   <= xpos_t'(1);    // Column 0 issued this cycle
            end else if (running) begin
                x_cnt <= x_cnt + 1'b1;
                if (x_cnt == LAST_X)
                    running <= 1'b0;
            end
            s1_valid  <= step;
            out_valid <= s1_valid;
        end
    end

    // Address register, then memory read register
    always_ff @(posedge clk) begin
        s1_x    <= step_x;
        s1_addr <= {src_row, src_col[SUB_W +: WSEL_W]};
        s1_sub  <= src_col[SUB_W-1:0];
        rd_word <= mem[s1_addr];
        out_x   <= s1_x;
        out_sub <= s1_sub;
    end

    // Disabled layer still streams, just transparent
    assign pix = '{
        valid: out_valid,
        x:     out_x,
        index: ctrl.enable ?
               rd_word[out_sub*$bits(color_idx_t) +: $bits(color_idx_t)] : '0
    };

    // ==================================================================
    // Checks
    // ==================================================================
    assign rendering = step || s1_valid || out_valid;

    a_no_wr_render: assert property (@(posedge clk) disable iff (!rst_n)
        wr_hit |-> !rendering)
        else $error("VRAM write to plane %0d during render", PLANE_SEL);

    // Stream runs 0..31 with no repeats, so never more than 32 valid cycles
    a_x_step: assert property (@(posedge clk) disable iff (!rst_n)
        pix.valid && $past(pix.valid) |-> pix.x == xpos_t'($past(pix.x) + 1'b1))
        else $error("Pixel stream skipped a column");

    a_stream_end: assert property (@(posedge clk) disable iff (!rst_n)
        pix.valid && (pix.x == LAST_X) |=> !pix.valid)
        else $error("Pixel stream longer than one row");

endmodule : layer_renderer

/* ppu/row_compositor.sv */
`timescale 1ns/1ps
`include "ppu_config.svh"

module row_compositor (
    input  logic                     clk,
    input  logic                     rst_n,

    // Display handshake
    input  logic                     row_req,
    input  ppu_types_pkg::row_t      next_row,
    output logic                     row_ack,

    // CPU side
    input  ppu_bus_pkg::layer_ctrl_t bg_ctrl,
    input  ppu_bus_pkg::layer_ctrl_t fg_ctrl,
    output logic                     cpu_wr_busy,

    // Renderer control and streams
    output logic                     render_start,
    output ppu_types_pkg::row_t      render_row,
    output ppu_bus_pkg::layer_ctrl_t bg_ctrl_q,
    output ppu_bus_pkg::layer_ctrl_t fg_ctrl_q,
    input  ppu_bus_pkg::layer_pix_t  bg_pix,
    input  ppu_bus_pkg::layer_pix_t  fg_pix,

    // Row buffer read port
    input  ppu_types_pkg::xpos_t     rowram_rdaddr,
    output ppu_types_pkg::pixel_t    rowram_rddata
);

    import ppu_types_pkg::*;
    import ppu_bus_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_RENDER,
        S_ACK_HOLD
    } state_t;

    localparam xpos_t LAST_X = xpos_t'(`PPU_ROW_PIXELS - 1);

    state_t state;
    logic   launch;       // Shadows loaded, start goes out next cycle
    logic   last_pix;
    pixel_t merged;
    pixel_t row_buf [`PPU_ROW_PIXELS];

    assign last_pix = bg_pix.valid && (bg_pix.x == LAST_X);

    // ==================================================================
    // Handshake FSM
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            row_ack      <= 1'b0;
            cpu_wr_busy  <= 1'b0;
            launch       <= 1'b0;
            render_start <= 1'b0;
        end else begin
            launch       <= 1'b0;
            render_start <= launch;
            case (state)
                S_IDLE: begin
                    if (row_req) begin
                        state       <= S_RENDER;
                        cpu_wr_busy <= 1'b1;
                        launch      <= 1'b1;
                    end
                end
                S_RENDER: begin
                    if (last_pix)
                        state <= S_ACK_HOLD;   // Last column written now
                end
                S_ACK_HOLD: begin
                    if (!row_req) begin
                        state       <= S_IDLE;
                        row_ack     <= 1'b0;
                        cpu_wr_busy <= 1'b0;
                    end else begin
                        row_ack <= 1'b1;       // Held as long as display waits
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Shadow copies, so mid-row CPU updates land on the next row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            render_row <= '0;
            bg_ctrl_q  <= '0;
            fg_ctrl_q  <= '0;
        end else if (state == S_IDLE && row_req) begin
            render_row <= next_row;
            bg_ctrl_q  <= bg_ctrl;
            fg_ctrl_q  <= fg_ctrl;
        end
    end

    // ==================================================================
    // Priority merge
    // ==================================================================
    always_comb begin
        if (fg_pix.index != '0)
            merged = {1'b1, fg_pix.index};
        else if (bg_pix.index != '0)
            merged = {1'b0, bg_pix.index};
        else
            merged = '0;                       // Backdrop
    end

    // ==================================================================
    // Row buffer
    // ==================================================================
    always_ff @(posedge clk) begin
        if (bg_pix.valid)
            row_buf[bg_pix.x] <= merged;
        rowram_rddata <= row_buf[rowram_rdaddr];
    end

    // Both renderers share one pipeline depth
    a_streams_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (bg_pix.valid == fg_pix.valid) && (!bg_pix.valid || bg_pix.x == fg_pix.x))
        else $error("Background and foreground streams out of step");

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(row_ack) |-> row_req)
        else $error("row_ack raised with no request pending");

endmodule : row_compositor

/* source/fpgame_ppu.sv */
`timescale 1ns/1ps

module fpgame_ppu (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ppu_bus_pkg::vram_wr_t    vram_wr,
    input  ppu_bus_pkg::layer_ctrl_t bg_ctrl,
    input  ppu_bus_pkg::layer_ctrl_t fg_ctrl,
    input  logic                     row_req,
    input  ppu_types_pkg::row_t      next_row,
    output logic                     row_ack,
    output logic                     cpu_wr_busy,
    input  ppu_types_pkg::xpos_t     rowram_rdaddr,
    output ppu_types_pkg::pixel_t    rowram_rddata
);

    import ppu_types_pkg::*;
    import ppu_bus_pkg::*;

    // ==================================================================
    // Compositor to renderer wiring
    // ==================================================================
    logic        render_start;
    row_t        render_row;
    layer_ctrl_t bg_ctrl_q;     // Row-shadowed copies
    layer_ctrl_t fg_ctrl_q;
    layer_pix_t  bg_pix;
    layer_pix_t  fg_pix;

    layer_renderer #(.PLANE_SEL(1'b0)) u_bg (
        .clk, .rst_n, .vram_wr,
        .start (render_start),
        .row   (render_row),
        .ctrl  (bg_ctrl_q),
        .pix   (bg_pix)
    );

    layer_renderer #(.PLANE_SEL(1'b1)) u_fg (
        .clk, .rst_n, .vram_wr,
        .start (render_start),
        .row   (render_row),
        .ctrl  (fg_ctrl_q),
        .pix   (fg_pix)
    );

    row_compositor u_comp (
        .clk, .rst_n, .row_req, .next_row, .row_ack, .bg_ctrl, .fg_ctrl, .cpu_wr_busy,
        .render_start, .render_row, .bg_ctrl_q, .fg_ctrl_q, .bg_pix, .fg_pix,
        .rowram_rdaddr, .rowram_rddata
    );

endmodule : fpgame_ppu

/* verification/tb_fpgame_ppu.sv */
`timescale 1ns/1ps
`include "ppu_config.svh"

module tb_fpgame_ppu;

    import ppu_types_pkg::*;
    import ppu_bus_pkg::*;

    localparam int TIMEOUT = 200;   // Cycles allowed per wait

    logic        clk;
    logic        rst_n;
    vram_wr_t    vram_wr;
    layer_ctrl_t bg_ctrl;
    layer_ctrl_t fg_ctrl;
    logic        row_req;
    row_t        next_row;
    logic        row_ack;
    logic        cpu_wr_busy;
    xpos_t       rowram_rdaddr;
    pixel_t      rowram_rddata;

    logic [15:0] lfsr;
    color_idx_t  bg_model [`PPU_PLANE_ROWS][`PPU_PLANE_COLS];
    color_idx_t  fg_model [`PPU_PLANE_ROWS][`PPU_PLANE_COLS];
    layer_ctrl_t bg_snap;   // Controls in force when the row was requested
    layer_ctrl_t fg_snap;

    fpgame_ppu dut0 (.*);

    always #2 clk = ~clk;

    // ==================================================================
    // Helpers
    // ==================================================================
    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at first error");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r[i] = lfsr_step();
        return r;
    endfunction

    // Roughly half the nibbles cleared so the foreground has holes
    function automatic vram_data_t sparse_word();
        vram_data_t  d;
        logic [15:0] keep;
        d    = rand_bits(64);
        keep = 16'(rand_bits(16));
        for (int p = 0; p < 16; p++)
            if (!keep[p])
                d[4*p +: 4] = '0;
        return d;
    endfunction

    function automatic void mirror_write(input vram_addr_t a, input vram_data_t d,
                                         input vram_be_t be);
        int r;
        int c;
        int p;
        r = int'(a[6:2]);
        for (int k = 0; k < 8; k++) begin
            if (be[k]) begin
                for (int j = 0; j < 2; j++) begin
                    p = 2 * k + j;
                    c = int'(a[1:0]) * `PPU_PIX_PER_WORD + p;
                    if (a[7])
                        fg_model[r][c] = d[4*p +: 4];
                    else
                        bg_model[r][c] = d[4*p +: 4];
                end
            end
        end
    endfunction

    task automatic vram_write(input vram_addr_t a, input vram_data_t d, input vram_be_t be);
        @(negedge clk);
        vram_wr = '{we: 1'b1, addr: a, data: d, be: be};
        mirror_write(a, d, be);
    endtask

    // Foreground wins unless transparent, then background, then backdrop
    function automatic pixel_t expected_pixel(input int r, input int x);
        color_idx_t b;
        color_idx_t f;
        b = bg_snap.enable ? bg_model[(r + int'(bg_snap.scroll_y)) % `PPU_PLANE_ROWS]
                                     [(x + int'(bg_snap.scroll_x)) % `PPU_PLANE_COLS] : '0;
        f = fg_snap.enable ? fg_model[(r + int'(fg_snap.scroll_y)) % `PPU_PLANE_ROWS]
                                     [(x + int'(fg_snap.scroll_x)) % `PPU_PLANE_COLS] : '0;
        if (f != '0)
            return {1'b1, f};
        else if (b != '0)
            return {1'b0, b};
        return '0;
    endfunction

    task automatic wait_level(input string sig, input logic level);
        int cycles;
        cycles = 0;
        while (((sig == "busy") ? cpu_wr_busy : row_ack) !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                fail_now($sformatf("ERROR: timed out waiting for %s to go %0b", sig, level));
        end
    endtask

    task automatic check_row(input string name, input int r);
        pixel_t exp;
        for (int x = 0; x < `PPU_ROW_PIXELS; x++) begin
            @(negedge clk);
            rowram_rdaddr = xpos_t'(x);
            @(negedge clk);                 // Read data registered by now
            exp = expected_pixel(r, x);
            assert (rowram_rddata == exp)
                else fail_now($sformatf("MISMATCH %s row %0d x %0d: expected %h, actual %h",
                                        name, r, x, exp, rowram_rddata));
        end
    endtask

    task automatic begin_request(input int r);
        @(negedge clk);
        next_row = row_t'(r);
        row_req  = 1'b1;
        bg_snap  = bg_ctrl;
        fg_snap  = fg_ctrl;
    endtask

    task automatic end_request();
        @(negedge clk);
        row_req = 1'b0;
        wait_level("ack", 1'b0);
    endtask

    task automatic run_row(input string name, input int r);
        begin_request(r);
        wait_level("ack", 1'b1);
        check_row(name, r);
        end_request();
    endtask

    // ==================================================================
    // Protocol checks
    // ==================================================================
    a_wr_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        vram_wr.we |-> !cpu_wr_busy)
        else fail_now("ERROR: VRAM write issued while cpu_wr_busy was high");

    a_busy_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cpu_wr_busy) |-> $past(row_req))
        else fail_now("ERROR: cpu_wr_busy rose with no row request");

    a_ack_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        row_ack |-> cpu_wr_busy)
        else fail_now("ERROR: row_ack high while cpu_wr_busy was low");

    a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(row_ack) |-> !$past(row_req) && !cpu_wr_busy)
        else fail_now("ERROR: row_ack fell before row_req dropped");

    // ==================================================================
    // Stimulus
    // ==================================================================
    initial begin
        vram_addr_t addr;
        clk           = 1'b0;
        rst_n         = 1'b0;
        vram_wr       = '0;
        bg_ctrl       = '0;
        fg_ctrl       = '0;
        row_req       = 1'b0;
        next_row      = '0;
        rowram_rdaddr = '0;
        lfsr          = 16'd47;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (16) begin                   // Quiet with no request
            @(negedge clk);
            assert (!row_ack && !cpu_wr_busy)
                else fail_now("ERROR: row_ack or cpu_wr_busy high with no request");
        end

        for (int w = 0; w < 2 * `PPU_PLANE_WORDS; w++) begin
            addr = vram_addr_t'(w);
            vram_write(addr, addr[7] ? sparse_word() : rand_bits(64), '1);
        end
        repeat (48)                         // Partial byte enables
            vram_write(vram_addr_t'(rand_bits(8)), rand_bits(64), vram_be_t'(rand_bits(8)));
        @(negedge clk);
        vram_wr = '0;

        bg_ctrl = '{scroll_x: '0, scroll_y: '0, enable: 1'b1};
        fg_ctrl = '0;
        for (int r = 0; r < `PPU_PLANE_ROWS; r++)
            run_row("bg_only", r);

        // Both axes wrap on both layers
        bg_ctrl = '{scroll_x: col_t'(50), scroll_y: row_t'(27), enable: 1'b1};
        fg_ctrl = '{scroll_x: col_t'(45), scroll_y: row_t'(9), enable: 1'b1};
        for (int r = 0; r < `PPU_PLANE_ROWS; r += 7)
            run_row("scroll_wrap", r);

        bg_ctrl = '{scroll_x: '0, scroll_y: '0, enable: 1'b1};
        fg_ctrl = '{scroll_x: '0, scroll_y: '0, enable: 1'b1};
        for (int r = 3; r < `PPU_PLANE_ROWS; r += 9)
            run_row("fg_priority", r);
        bg_ctrl.enable = 1'b0;
        run_row("fg_only", 12);

        // Controls changed mid-row
        bg_ctrl = '{scroll_x: col_t'(7), scroll_y: row_t'(2), enable: 1'b1};
        fg_ctrl = '{scroll_x: '0, scroll_y: '0, enable: 1'b0};
        begin_request(6);
        wait_level("busy", 1'b1);
        bg_ctrl = '{scroll_x: col_t'(33), scroll_y: row_t'(19), enable: 1'b1};
        fg_ctrl = '{scroll_x: col_t'(60), scroll_y: row_t'(30), enable: 1'b1};
        wait_level("ack", 1'b1);
        check_row("shadow_current", 6);
        end_request();
        run_row("shadow_next", 7);

        // Display stalls with row_req held
        begin_request(17);
        wait_level("ack", 1'b1);
        check_row("hold_before", 17);
        bg_ctrl = '{scroll_x: col_t'(21), scroll_y: row_t'(5), enable: 1'b0};
        fg_ctrl = '{scroll_x: col_t'(3), scroll_y: row_t'(11), enable: 1'b1};  // Held row keeps old
        repeat (60) begin
            @(negedge clk);
            assert (row_ack)
                else fail_now("ERROR: row_ack dropped while row_req was held high");
        end
        check_row("hold_after", 17);
        end_request();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : tb_fpgame_ppu

/* sim.f */
+incdir+common
common/ppu_types_pkg.sv
common/ppu_bus_pkg.sv
ppu/layer_renderer.sv
ppu/row_compositor.sv
source/fpgame_ppu.sv
verification/tb_fpgame_ppu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PPU testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_fpgame_ppu -o sim_tb

# The log decides the result, not the exit status
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -qF '*** TEST PASSED ***' sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
